//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_controller_standby_i3c
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/controller_standby_i3c_checker.sv
// Bound assertions on RX queue handshake, bus pin outputs and reset values
`timescale 1ns/1ns

module controller_standby_i3c_checker
  import i3c_target_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  scl_sync_i,
  input logic  scl_out_i,
  input logic  sda_out_i,
  input logic  phy_sel_i,
  input logic  rx_wvalid_i,
  input logic  rx_wready_i,
  input word_t rx_wdata_i,
  input logic  tx_rready_i,
  input logic  bus_free_i,
  input logic  bus_idle_i,
  input logic  bus_available_i
);

  int unsigned fail_cnt = 0;

  // RX word holds until the queue takes it
  a_wvalid_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_wvalid_i && !rx_wready_i |=> rx_wvalid_i && $stable(rx_wdata_i)
  ) else begin
    $error("RX queue word changed or dropped before wready");
    fail_cnt++;
  end

  a_scl_high: assert property (@(posedge clk_i) disable iff (!rst_n_i) scl_out_i)
  else begin
    $error("SCL output pulled low");
    fail_cnt++;
  end

  a_open_drain: assert property (@(posedge clk_i) disable iff (!rst_n_i) !phy_sel_i)
  else begin
    $error("PHY select switched to push-pull");
    fail_cnt++;
  end

  // Target only moves SDA while SCL is low
  a_sda_scl_low: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (sda_out_i != $past(sda_out_i)) |-> !scl_sync_i
  ) else begin
    $error("SDA output changed while SCL was high");
    fail_cnt++;
  end

  a_reset_quiet: assert property (
    @(posedge clk_i)
    !rst_n_i |=> !rx_wvalid_i && !tx_rready_i && sda_out_i &&
                 !bus_free_i && !bus_idle_i && !bus_available_i
  ) else begin
    $error("Output active right after reset");
    fail_cnt++;
  end

endmodule

bind controller_standby_i3c controller_standby_i3c_checker u_checker (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .scl_sync_i     (bus_scl),
  .scl_out_i      (ctrl_scl_o),
  .sda_out_i      (ctrl_sda_o),
  .phy_sel_i      (phy_sel_od_pp_o),
  .rx_wvalid_i    (rx_queue_wvalid_o),
  .rx_wready_i    (rx_queue_wready_i),
  .rx_wdata_i     (rx_queue_wdata_o),
  .tx_rready_i    (tx_queue_rready_o),
  .bus_free_i     (bus_free_o),
  .bus_idle_i     (bus_idle_o),
  .bus_available_i(bus_available_o)
);

//--- dv/tb_controller_standby_i3c.sv
// Testbench with clock, reset, bus controller model, RX/TX queue models and tests
`timescale 1ns/1ns

module tb_controller_standby_i3c
  import i3c_target_pkg::*;
();

  localparam addr_t StaticAddr = 7'h2a;
  localparam addr_t DynamicAddr = 7'h51;
  localparam addr_t OtherAddr = 7'h33;
  // 5 tests, about 12 bytes of 9 bits at 12 clocks each, plus margin
  localparam int TimeoutCycles = 5 * 12 * 9 * 12 + 3000;

  logic        clk;
  logic        rst_n;
  logic        en;
  logic        scl;
  logic        sda_drv;
  logic        sda_line;
  addr_cfg_t   addr_cfg;
  bus_timing_t timing;
  logic        rx_wready;
  logic        tx_rvalid;
  word_t       tx_rdata;
  logic        scl_out;
  logic        sda_out;
  logic        phy_sel;
  logic        rx_wvalid;
  word_t       rx_wdata;
  logic        tx_rready;
  logic        bus_free;
  logic        bus_idle;
  logic        bus_avail;

  word_t       rx_words[$];
  int          rx_rd;
  word_t       tx_words[4];
  int          tx_count;
  int          tx_base;
  int          tx_pops = 0;
  int          cycles = 0;
  logic [31:0] lcg_state;
  string       test_name;
  int          test_errs;
  int          tests_run;
  int          tests_bad;

  // Open-drain SDA seen by the DUT
  assign sda_line = sda_drv & sda_out;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  controller_standby_i3c u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .i3c_standby_en_i (en),
    .ctrl_scl_i       (scl),
    .ctrl_sda_i       (sda_line),
    .ctrl_scl_o       (scl_out),
    .ctrl_sda_o       (sda_out),
    .phy_sel_od_pp_o  (phy_sel),
    .addr_cfg_i       (addr_cfg),
    .timing_i         (timing),
    .rx_queue_wvalid_o(rx_wvalid),
    .rx_queue_wready_i(rx_wready),
    .rx_queue_wdata_o (rx_wdata),
    .tx_queue_rvalid_i(tx_rvalid),
    .tx_queue_rready_o(tx_rready),
    .tx_queue_rdata_i (tx_rdata),
    .bus_free_o       (bus_free),
    .bus_idle_o       (bus_idle),
    .bus_available_o  (bus_avail)
  );

  // Queue models record handshakes
  always @(posedge clk) begin
    if (rx_wvalid && rx_wready) begin
      rx_words.push_back(rx_wdata);
    end
    if (tx_rvalid && tx_rready) begin
      tx_pops <= tx_pops + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: run exceeded %0d cycles", TimeoutCycles);
      $display("tests failed");
      $finish;
    end
  end

  // One falling edge, TX queue outputs follow the pop count
  task automatic tick();
    @(negedge clk);
    tx_rvalid = (tx_pops - tx_base) < tx_count;
    tx_rdata  = tx_words[2'(tx_pops - tx_base)];
  endtask

  task automatic wait_clks(input int n);
    repeat (n) tick();
  endtask

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic check_val(input string what, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("Error: test %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("Error: test %s: %s expected %b actual %b", test_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic expect_word(input word_t expected);
    int waited;
    waited = 0;
    while (rx_words.size() <= rx_rd && waited < 200) begin
      tick();
      waited++;
    end
    assert (rx_words.size() > rx_rd) else begin
      $display("test %s: no RX queue word arrived in time", test_name);
      test_errs++;
    end
    if (rx_words.size() > rx_rd) begin
      check_val("rx word", expected, rx_words[rx_rd]);
      rx_rd++;
    end
  endtask

  task automatic expect_no_word();
    wait_clks(20);
    check_val("rx word count", rx_rd, rx_words.size());
  endtask

  // START from idle, or repeated START with SCL low
  task automatic drive_start();
    if (!scl) begin
      sda_drv = 1'b1;
      wait_clks(5);
      scl = 1'b1;
      wait_clks(6);
    end
    sda_drv = 1'b0;
    wait_clks(6);
    scl = 1'b0;
    wait_clks(1);
  endtask

  task automatic drive_stop();
    sda_drv = 1'b0;
    wait_clks(5);
    scl = 1'b1;
    wait_clks(6);
    sda_drv = 1'b1;
  endtask

  task automatic send_bit(input logic value);
    sda_drv = value;
    wait_clks(5);
    scl = 1'b1;
    wait_clks(6);
    scl = 1'b0;
    wait_clks(1);
  endtask

  task automatic recv_bit(output logic value);
    sda_drv = 1'b1;
    wait_clks(5);
    scl = 1'b1;
    wait_clks(5);
    value = sda_line;
    wait_clks(1);
    scl = 1'b0;
    wait_clks(1);
  endtask

  task automatic write_byte(input byte_t data, output logic ack);
    logic line;
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);
    end
    recv_bit(line);
    ack = !line;
  endtask

  task automatic read_byte(output byte_t data, input logic ack);
    logic line;
    data = '0;
    for (int i = 0; i < 8; i++) begin
      recv_bit(line);
      data = {data[6:0], line};
    end
    send_bit(!ack);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  initial begin
    byte_t data[6];
    byte_t b;
    byte_t exp_byte;
    logic  ack;
    int    exp_pops;
    rst_n     = 1'b0;
    en        = 1'b1;
    scl       = 1'b1;
    sda_drv   = 1'b1;
    addr_cfg  = '{static_valid: 1'b1, static_addr: StaticAddr,
                  dynamic_valid: 1'b1, dynamic_addr: DynamicAddr};
    timing    = '{t_bus_free: 20'd5, t_bus_idle: 20'd12, t_bus_available: 20'd20};
    rx_wready = 1'b1;
    tx_rvalid = 1'b0;
    tx_rdata  = '0;
    lcg_state = 32'hdfe1c9e8;
    rx_rd     = 0;
    tx_count  = 0;
    tx_base   = 0;
    tests_run = 0;
    tests_bad = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    wait_clks(4);

    // Six bytes to the static address, one full and one partial word
    begin_test("write_static");
    drive_start();
    write_byte({StaticAddr, 1'b0}, ack);
    check_bit("address ack", 1'b1, ack);
    for (int i = 0; i < 6; i++) begin
      data[i] = rand_byte();
      write_byte(data[i], ack);
      check_bit("data ack", 1'b1, ack);
    end
    drive_stop();
    expect_word({data[3], data[2], data[1], data[0]});
    expect_word({16'h0000, data[5], data[4]});
    wait_clks(10);
    end_test();

    begin_test("address_match");
    drive_start();
    write_byte({DynamicAddr, 1'b0}, ack);
    check_bit("dynamic address ack", 1'b1, ack);
    for (int i = 0; i < 2; i++) begin
      data[i] = rand_byte();
      write_byte(data[i], ack);
      check_bit("data ack", 1'b1, ack);
    end
    drive_stop();
    expect_word({16'h0000, data[1], data[0]});
    wait_clks(10);
    drive_start();
    write_byte({OtherAddr, 1'b0}, ack);
    check_bit("unknown address ack", 1'b0, ack);
    write_byte(data[0], ack);
    drive_stop();
    expect_no_word();
    // Dynamic entry present but not valid
    addr_cfg.dynamic_valid = 1'b0;
    drive_start();
    write_byte({DynamicAddr, 1'b0}, ack);
    check_bit("invalid dynamic address ack", 1'b0, ack);
    write_byte(data[1], ack);
    drive_stop();
    expect_no_word();
    addr_cfg.dynamic_valid = 1'b1;
    wait_clks(10);
    end_test();

    // Two TX words, then idle bytes once the queue runs dry
    begin_test("read_static");
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 4; j++) begin
        b = rand_byte();
        tx_words[i][8 * j +: 8] = b;
      end
    end
    tx_base  = tx_pops;
    tx_count = 2;
    drive_start();
    write_byte({StaticAddr, 1'b1}, ack);
    check_bit("address ack", 1'b1, ack);
    for (int i = 0; i < 10; i++) begin
      read_byte(b, i < 9);
      exp_byte = (i < 8) ? tx_words[i / 4][8 * (i % 4) +: 8] : 8'hff;
      check_val("read byte", word_t'(exp_byte), word_t'(b));
      exp_pops = (i + 1) / 4 + 1;
      if (exp_pops > 2) begin
        exp_pops = 2;
      end
      check_val("tx queue pops", exp_pops, tx_pops - tx_base);
    end
    drive_stop();
    wait_clks(10);
    tx_count = 0;
    end_test();

    begin_test("rx_backpressure");
    rx_wready = 1'b0;
    drive_start();
    write_byte({StaticAddr, 1'b0}, ack);
    check_bit("address ack", 1'b1, ack);
    for (int i = 0; i < 5; i++) begin
      data[i] = rand_byte();
      write_byte(data[i], ack);
      check_bit("data ack", i < 4, ack);
    end
    drive_stop();
    // Full word stays offered while the queue refuses it
    wait_clks(20);
    check_bit("rx word pending", 1'b1, rx_wvalid);
    rx_wready = 1'b1;
    expect_word({data[3], data[2], data[1], data[0]});
    expect_no_word();
    end_test();

    begin_test("bus_timers");
    drive_start();
    write_byte({StaticAddr, 1'b0}, ack);
    check_bit("address ack", 1'b1, ack);
    check_bit("bus free in transfer", 1'b0, bus_free);
    check_bit("bus idle in transfer", 1'b0, bus_idle);
    check_bit("bus available in transfer", 1'b0, bus_avail);
    drive_stop();
    // Counted from the SDA rise of the STOP
    for (int n = 1; n <= 25; n++) begin
      tick();
      check_bit("bus free", n >= int'(timing.t_bus_free) + 3, bus_free);
      check_bit("bus idle", n >= int'(timing.t_bus_idle) + 3, bus_idle);
      check_bit("bus available", n >= int'(timing.t_bus_available) + 3, bus_avail);
    end
    drive_start();
    check_bit("bus free after start", 1'b0, bus_free);
    check_bit("bus idle after start", 1'b0, bus_idle);
    check_bit("bus available after start", 1'b0, bus_avail);
    drive_stop();
    wait_clks(10);
    end_test();

    $display("summary: %0d tests run, %0d with errors, %0d checker failures",
             tests_run, tests_bad, u_dut.u_checker.fail_cnt);
    if (tests_bad == 0 && u_dut.u_checker.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/i3c_target_pkg.sv
verilog/bus_monitor.sv
verilog/bus_timers.sv
verilog/i3c_target_fsm.sv
verilog/flow_standby_i3c.sv
verilog/controller_standby_i3c.sv
dv/controller_standby_i3c_checker.sv
dv/tb_controller_standby_i3c.sv

//--- verilog/bus_monitor.sv
// SCL/SDA synchronizer with START, STOP and SCL edge detection
`timescale 1ns/1ns

module bus_monitor
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output logic       scl_o,
  output logic       sda_o,
  output bus_event_t events_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_prev_q;
  logic                  sda_prev_q;
  bus_event_t            events_d;

  assign scl_o = scl_sync_q[SyncStages-1];
  assign sda_o = sda_sync_q[SyncStages-1];

  // SDA edges only count as START/STOP while SCL stays high
  always_comb begin
    events_d.start_det = scl_prev_q && scl_o && sda_prev_q && !sda_o;
    events_d.stop_det  = scl_prev_q && scl_o && !sda_prev_q && sda_o;
    events_d.scl_rise  = !scl_prev_q && scl_o;
    events_d.scl_fall  = scl_prev_q && !scl_o;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      events_o   <= '0;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_o;
      sda_prev_q <= sda_o;
      if (enable_i) begin
        events_o <= events_d;
      end else begin
        events_o <= '0;
      end
    end
  end

endmodule

//--- verilog/bus_timers.sv
// Bus free, idle and available timers started by STOP
`timescale 1ns/1ns

module bus_timers
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        enable_i,
  input  bus_event_t  events_i,
  input  bus_timing_t timing_i,
  output logic        bus_free_o,
  output logic        bus_idle_o,
  output logic        bus_available_o
);

  timer_t cnt_q;
  timer_t cnt_d;
  logic   run_q;
  logic   run_d;

  // Count restarts at 1 so an output rises t cycles after the STOP pulse
  always_comb begin
    cnt_d = cnt_q;
    run_d = run_q;
    if (events_i.stop_det) begin
      cnt_d = timer_t'(1);
      run_d = 1'b1;
    end else if (run_q && cnt_q != '1) begin
      cnt_d = cnt_q + timer_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !enable_i || events_i.start_det) begin
      cnt_q           <= '0;
      run_q           <= 1'b0;
      bus_free_o      <= 1'b0;
      bus_idle_o      <= 1'b0;
      bus_available_o <= 1'b0;
    end else begin
      cnt_q           <= cnt_d;
      run_q           <= run_d;
      bus_free_o      <= run_d && (cnt_d >= timing_i.t_bus_free);
      bus_idle_o      <= run_d && (cnt_d >= timing_i.t_bus_idle);
      bus_available_o <= run_d && (cnt_d >= timing_i.t_bus_available);
    end
  end

endmodule

//--- verilog/controller_standby_i3c.sv
// Standby I3C target top level with bus monitor, bus timers, target FSM and queue flow
`timescale 1ns/1ns

module controller_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        i3c_standby_en_i,

  // Bus pins
  input  logic        ctrl_scl_i,
  input  logic        ctrl_sda_i,
  output logic        ctrl_scl_o,
  output logic        ctrl_sda_o,
  output logic        phy_sel_od_pp_o,

  // Configuration
  input  addr_cfg_t   addr_cfg_i,
  input  bus_timing_t timing_i,

  // RX data queue
  output logic        rx_queue_wvalid_o,
  input  logic        rx_queue_wready_i,
  output word_t       rx_queue_wdata_o,

  // TX data queue
  input  logic        tx_queue_rvalid_i,
  output logic        tx_queue_rready_o,
  input  word_t       tx_queue_rdata_i,

  // Bus state
  output logic        bus_free_o,
  output logic        bus_idle_o,
  output logic        bus_available_o
);

  bus_event_t bus_events;
  logic       bus_scl;
  logic       bus_sda;
  logic       rx_byte_valid;
  byte_t      rx_byte;
  logic       rx_byte_ready;
  logic       tx_byte_valid;
  byte_t      tx_byte;
  logic       tx_byte_ready;
  logic       transfer_start;
  logic       transfer_stop;

  // Open drain only, SCL never held low
  assign ctrl_scl_o      = 1'b1;
  assign phy_sel_od_pp_o = 1'b0;

  bus_monitor xbus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .enable_i(i3c_standby_en_i),
    .scl_i   (ctrl_scl_i),
    .sda_i   (ctrl_sda_i),
    .scl_o   (bus_scl),
    .sda_o   (bus_sda),
    .events_o(bus_events)
  );

  bus_timers xbus_timers (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enable_i       (i3c_standby_en_i),
    .events_i       (bus_events),
    .timing_i       (timing_i),
    .bus_free_o     (bus_free_o),
    .bus_idle_o     (bus_idle_o),
    .bus_available_o(bus_available_o)
  );

  i3c_target_fsm xi3c_target_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .enable_i        (i3c_standby_en_i),
    .events_i        (bus_events),
    .sda_i           (bus_sda),
    .addr_cfg_i      (addr_cfg_i),
    .rx_byte_ready_i (rx_byte_ready),
    .tx_byte_valid_i (tx_byte_valid),
    .tx_byte_i       (tx_byte),
    .sda_o           (ctrl_sda_o),
    .rx_byte_valid_o (rx_byte_valid),
    .rx_byte_o       (rx_byte),
    .tx_byte_ready_o (tx_byte_ready),
    .transfer_start_o(transfer_start),
    .transfer_stop_o (transfer_stop)
  );

  flow_standby_i3c xflow_standby_i3c (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .transfer_start_i (transfer_start),
    .transfer_stop_i  (transfer_stop),
    .rx_byte_valid_i  (rx_byte_valid),
    .rx_byte_i        (rx_byte),
    .tx_byte_ready_i  (tx_byte_ready),
    .rx_queue_wready_i(rx_queue_wready_i),
    .tx_queue_rvalid_i(tx_queue_rvalid_i),
    .tx_queue_rdata_i (tx_queue_rdata_i),
    .rx_byte_ready_o  (rx_byte_ready),
    .tx_byte_valid_o  (tx_byte_valid),
    .tx_byte_o        (tx_byte),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .tx_queue_rready_o(tx_queue_rready_o)
  );

endmodule

//--- verilog/flow_standby_i3c.sv
// RX byte packer and TX word unpacker between the target FSM and the data queues
`timescale 1ns/1ns

module flow_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  transfer_start_i,
  input  logic  transfer_stop_i,
  input  logic  rx_byte_valid_i,
  input  byte_t rx_byte_i,
  input  logic  tx_byte_ready_i,
  input  logic  rx_queue_wready_i,
  input  logic  tx_queue_rvalid_i,
  input  word_t tx_queue_rdata_i,
  output logic  rx_byte_ready_o,
  output logic  tx_byte_valid_o,
  output byte_t tx_byte_o,
  output logic  rx_queue_wvalid_o,
  output word_t rx_queue_wdata_o,
  output logic  tx_queue_rready_o
);

  logic [ByteIdxW-1:0] rx_idx_q;
  logic [ByteIdxW-1:0] tx_idx_q;
  word_t               tx_word_q;
  logic                tx_have_q;
  logic                rx_take;
  logic                rx_last;
  logic                tx_take;
  logic                tx_last;
  logic                tx_pop;

  // RX side, one word in flight blocks further bytes
  assign rx_byte_ready_o = !rx_queue_wvalid_o;
  assign rx_take         = rx_byte_valid_i && rx_byte_ready_o;
  assign rx_last         = rx_idx_q == ByteIdxW'(WordBytes - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_idx_q          <= '0;
      rx_queue_wvalid_o <= 1'b0;
    end else if (rx_take) begin
      rx_idx_q          <= rx_last ? '0 : rx_idx_q + 1'b1;
      rx_queue_wvalid_o <= rx_last;
    end else if ((transfer_start_i || transfer_stop_i) && rx_idx_q != '0) begin
      // Flush a partial word
      rx_idx_q          <= '0;
      rx_queue_wvalid_o <= 1'b1;
    end else if (rx_queue_wvalid_o && rx_queue_wready_i) begin
      rx_queue_wvalid_o <= 1'b0;
    end
  end

  // First byte of a word clears the rest so a flush is zero filled
  always_ff @(posedge clk_i) begin
    if (rx_take) begin
      if (rx_idx_q == '0) begin
        rx_queue_wdata_o <= word_t'(rx_byte_i);
      end else begin
        rx_queue_wdata_o[{rx_idx_q, 3'b000} +: 8] <= rx_byte_i;
      end
    end
  end

  // TX side
  assign tx_byte_valid_o   = tx_have_q;
  assign tx_byte_o         = tx_word_q[{tx_idx_q, 3'b000} +: 8];
  assign tx_queue_rready_o = tx_byte_ready_i && !tx_have_q && !transfer_stop_i;
  assign tx_pop            = tx_queue_rvalid_i && tx_queue_rready_o;
  assign tx_take           = tx_have_q && tx_byte_ready_i;
  assign tx_last           = tx_idx_q == ByteIdxW'(WordBytes - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_have_q <= 1'b0;
      tx_idx_q  <= '0;
    end else if (transfer_stop_i) begin
      tx_have_q <= 1'b0;
    end else if (tx_pop) begin
      tx_have_q <= 1'b1;
      tx_idx_q  <= '0;
    end else if (tx_take) begin
      tx_have_q <= !tx_last;
      tx_idx_q  <= tx_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_pop) begin
      tx_word_q <= tx_queue_rdata_i;
    end
  end

endmodule

//--- verilog/i3c_target_fsm.sv
// I3C SDR target FSM with address match, ACK/NACK, byte receive and transmit
`timescale 1ns/1ns

module i3c_target_fsm
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  bus_event_t events_i,
  input  logic       sda_i,
  input  addr_cfg_t  addr_cfg_i,
  input  logic       rx_byte_ready_i,
  input  logic       tx_byte_valid_i,
  input  byte_t      tx_byte_i,
  output logic       sda_o,
  output logic       rx_byte_valid_o,
  output byte_t      rx_byte_o,
  output logic       tx_byte_ready_o,
  output logic       transfer_start_o,
  output logic       transfer_stop_o
);

  target_state_e state_q;
  byte_t         shift_q;
  logic [3:0]    bit_cnt_q;
  logic          rw_q;
  logic          sda_q;
  logic          tx_req_q;
  logic          tx_loaded_q;
  addr_t         bus_addr;
  logic          addr_hit;
  logic          tx_take;
  byte_t         tx_next;

  // Address byte is 7 address bits then R/W in bit 0
  assign bus_addr = shift_q[7:1];
  assign addr_hit = (addr_cfg_i.static_valid && bus_addr == addr_cfg_i.static_addr) ||
                    (addr_cfg_i.dynamic_valid && bus_addr == addr_cfg_i.dynamic_addr);

  assign tx_take = tx_req_q && tx_byte_valid_i;

  // Byte to shift out at the start of a read byte
  always_comb begin
    if (tx_loaded_q) begin
      tx_next = shift_q;
    end else if (tx_take) begin
      tx_next = tx_byte_i;
    end else begin
      tx_next = TxIdleByte;
    end
  end

  assign sda_o            = sda_q;
  assign rx_byte_o        = shift_q;
  assign tx_byte_ready_o  = tx_req_q;
  assign transfer_start_o = enable_i && events_i.start_det;
  assign transfer_stop_o  = enable_i && events_i.stop_det && (state_q != IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q         <= IDLE;
      bit_cnt_q       <= '0;
      rw_q            <= 1'b0;
      sda_q           <= 1'b1;
      tx_req_q        <= 1'b0;
      tx_loaded_q     <= 1'b0;
      rx_byte_valid_o <= 1'b0;
    end else begin
      if (rx_byte_valid_o && rx_byte_ready_i) begin
        rx_byte_valid_o <= 1'b0;
      end
      // Next read byte lands in the idle shift register during the ACK slot
      if (tx_take) begin
        shift_q     <= tx_byte_i;
        tx_loaded_q <= 1'b1;
        tx_req_q    <= 1'b0;
      end

      if (!enable_i || events_i.stop_det) begin
        state_q     <= IDLE;
        sda_q       <= 1'b1;
        tx_req_q    <= 1'b0;
        tx_loaded_q <= 1'b0;
      end else if (events_i.start_det) begin
        // START and repeated START both restart address capture
        state_q     <= ADDR;
        bit_cnt_q   <= '0;
        sda_q       <= 1'b1;
        tx_req_q    <= 1'b0;
        tx_loaded_q <= 1'b0;
      end else begin
        unique case (state_q)
          ADDR, RX_DATA: begin
            if (events_i.scl_rise) begin
              shift_q   <= {shift_q[6:0], sda_i};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (events_i.scl_fall && bit_cnt_q == 4'd8) begin
              bit_cnt_q <= '0;
              if (state_q == ADDR) begin
                rw_q <= shift_q[0];
                if (addr_hit) begin
                  sda_q   <= 1'b0;
                  state_q <= ADDR_ACK;
                end else begin
                  state_q <= WAIT_STOP;
                end
              end else begin
                // No room downstream means NACK and the byte is lost
                state_q <= RX_ACK;
                if (rx_byte_ready_i) begin
                  sda_q           <= 1'b0;
                  rx_byte_valid_o <= 1'b1;
                end else begin
                  sda_q <= 1'b1;
                end
              end
            end
          end

          RX_ACK: begin
            if (events_i.scl_fall) begin
              bit_cnt_q <= '0;
              sda_q     <= 1'b1;
              state_q   <= sda_q ? WAIT_STOP : RX_DATA;
            end
          end

          ADDR_ACK, TX_ACK: begin
            if (events_i.scl_rise) begin
              if (state_q == TX_ACK && sda_i) begin
                // Controller NACK ends the read
                state_q <= WAIT_STOP;
              end else if (rw_q) begin
                tx_req_q <= 1'b1;
              end
            end else if (events_i.scl_fall) begin
              if (rw_q) begin
                shift_q     <= tx_next;
                sda_q       <= tx_next[7];
                bit_cnt_q   <= 4'd1;
                tx_req_q    <= 1'b0;
                tx_loaded_q <= 1'b0;
                state_q     <= TX_DATA;
              end else begin
                sda_q     <= 1'b1;
                bit_cnt_q <= '0;
                state_q   <= RX_DATA;
              end
            end
          end

          TX_DATA: begin
            if (events_i.scl_fall) begin
              if (bit_cnt_q == 4'd8) begin
                sda_q   <= 1'b1;
                state_q <= TX_ACK;
              end else begin
                sda_q     <= shift_q[6];
                shift_q   <= {shift_q[6:0], 1'b0};
                bit_cnt_q <= bit_cnt_q + 4'd1;
              end
            end
          end

          default: ;
        endcase
      end
    end
  end

endmodule

//--- verilog/i3c_target_pkg.sv
// Shared widths, address and timing config structs, bus events, target FSM states
package i3c_target_pkg;

  // Bytes per RX/TX queue word
  localparam int unsigned WordBytes = 4;
  localparam int unsigned ByteIdxW = $clog2(WordBytes);

  // Depth of the SCL/SDA synchronizer
  localparam int unsigned SyncStages = 2;

  // Sent on a read when the TX queue has nothing left
  localparam logic [7:0] TxIdleByte = 8'hff;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [19:0] timer_t;

  typedef struct packed {
    logic  static_valid;
    addr_t static_addr;
    logic  dynamic_valid;
    addr_t dynamic_addr;
  } addr_cfg_t;

  typedef struct packed {
    timer_t t_bus_free;
    timer_t t_bus_idle;
    timer_t t_bus_available;
  } bus_timing_t;

  // One-cycle pulses from the bus monitor
  typedef struct packed {
    logic start_det;
    logic stop_det;
    logic scl_rise;
    logic scl_fall;
  } bus_event_t;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    RX_DATA,
    RX_ACK,
    TX_DATA,
    TX_ACK,
    WAIT_STOP
  } target_state_e;

endpackage
